// ==== rtl/dll_rx_framer.sv ====
// ************************************************************
// input side of the DLL receive path
// the sequence word passes straight through, TLP dwords are
// held one word so the final one is known when LCRC arrives
// ************************************************************
`timescale 1ns/1ps
`default_nettype none

module dll_rx_framer
  import dll_rx_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_i,
  input  axis_word_t          s_word_i,
  input  logic                s_valid_i,
  output logic                s_ready_o,
  output rx_word_t            rx_word_o,
  output logic                rx_valid_o,
  input  logic                rx_take_i,
  output logic [DW_WIDTH-1:0] lcrc_word_o,
  output logic                lcrc_valid_o
);

  logic [DW_WIDTH-1:0] hold_data_q;
  logic                hold_valid_q;
  // sequence word consumed, first TLP dword not yet held
  logic                load_pend_q;

  always_comb begin
    rx_word_o.data  = hold_valid_q ? hold_data_q : s_word_i.data;
    rx_word_o.first = !hold_valid_q;
    rx_word_o.last  = hold_valid_q && s_word_i.last;
    rx_valid_o      = s_valid_i && !load_pend_q;
    lcrc_word_o     = s_word_i.data;
    lcrc_valid_o    = s_valid_i && hold_valid_q && s_word_i.last;
    s_ready_o       = load_pend_q || rx_take_i;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      hold_valid_q <= 1'b0;
      load_pend_q  <= 1'b0;
    end else if (load_pend_q && s_valid_i) begin
      load_pend_q  <= 1'b0;
      hold_valid_q <= 1'b1;
    end else if (rx_take_i) begin
      if (!hold_valid_q) begin
        load_pend_q <= 1'b1;
      end else if (s_word_i.last) begin
        // LCRC consumed together with the final dword
        hold_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if ((load_pend_q && s_valid_i) || (rx_take_i && hold_valid_q)) begin
      hold_data_q <= s_word_i.data;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/dll_rx_pkg.sv ====
// ************************************************************
// shared constants and types of the PCIe DLL receive path
// words are full 32-bit dwords, byte 0 in bits 7:0
// ************************************************************
`default_nettype none

package dll_rx_pkg;

  localparam int DW_WIDTH        = 32;
  localparam int SEQ_WIDTH       = 12;
  localparam int CRED_HDR_WIDTH  = 8;
  localparam int CRED_DATA_WIDTH = 12;

  localparam logic [CRED_HDR_WIDTH-1:0] HDR_MIN_CREDITS = 8'd1;
  localparam logic [DW_WIDTH-1:0] LCRC_INIT = 32'hFFFF_FFFF;
  localparam logic [DW_WIDTH-1:0] LCRC_POLY = 32'h04C1_1DB7;

  typedef enum logic [7:0] {
    MRd32    = 8'h00,
    MRdLk    = 8'h01,
    IORd     = 8'h02,
    CfgRd0   = 8'h04,
    CfgRd1   = 8'h05,
    MRd64    = 8'h20,
    Msg      = 8'h30,
    MWr32    = 8'h40,
    IOWr     = 8'h42,
    CfgWr0   = 8'h44,
    CfgWr1   = 8'h45,
    FetchAdd = 8'h4C,
    Swap     = 8'h4D,
    CAS      = 8'h4E,
    MWr64    = 8'h60,
    MsgD     = 8'h70
  } tlp_fmt_type_e;

  typedef enum logic [2:0] {
    CLS_NONE,
    CLS_PH,
    CLS_PD,
    CLS_NPH,
    CLS_NPD
  } tlp_class_e;

  // first header dword as it arrives on the wire
  typedef struct packed {
    logic [7:0] length_lo;
    logic [5:0] misc;
    logic [1:0] length_hi;
    logic [7:0] tc_attr;
    logic [7:0] fmt_type;
  } tlp_dw0_t;

  typedef struct packed {
    logic [DW_WIDTH-1:0] data;
    logic                last;
  } axis_word_t;

  typedef struct packed {
    logic [DW_WIDTH-1:0] data;
    logic                first;
    logic                last;
  } rx_word_t;

  typedef struct packed {
    logic [CRED_HDR_WIDTH-1:0]  ph;
    logic [CRED_DATA_WIDTH-1:0] pd;
    logic [CRED_HDR_WIDTH-1:0]  nph;
    logic [CRED_DATA_WIDTH-1:0] npd;
  } credit_counts_t;

  typedef struct packed {
    logic valid;
    logic good;
  } frame_verdict_t;

endpackage

`default_nettype wire

// ==== rtl/dll_rx_top.sv ====
// ************************************************************
// PCIe DLL receive path, one frame per TLP
// frame = sequence word, TLP dwords, LCRC word with last
// fc_start_o must be acknowledged before the next frame
// ************************************************************
`timescale 1ns/1ps
`default_nettype none

module dll_rx_top
  import dll_rx_pkg::*;
#(
  parameter int MAX_PAYLOAD_DW = 64,
  parameter int RX_FIFO_FRAMES = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 link_active_i,
  input  axis_word_t           s_word_i,
  input  logic                 s_valid_i,
  output logic                 s_ready_o,
  output axis_word_t           m_word_o,
  output logic                 m_valid_o,
  input  logic                 m_ready_i,
  output logic                 fc_start_o,
  input  logic                 fc_start_ack_i,
  output logic [SEQ_WIDTH-1:0] rx_seq_o,
  output logic                 tlp_nullified_o,
  output credit_counts_t       credits_o
);

  // header plus payload per frame, rounded up to a power of two
  localparam int FIFO_WORDS = RX_FIFO_FRAMES * (MAX_PAYLOAD_DW + 4);
  localparam int FIFO_DEPTH = 1 << $clog2(FIFO_WORDS);

  rx_word_t            rx_word;
  logic                rx_valid;
  logic                rx_take;
  logic [DW_WIDTH-1:0] lcrc_word;
  logic                lcrc_valid;
  logic [DW_WIDTH-1:0] crc;
  logic                crc_clear;
  logic                fifo_space;
  frame_verdict_t      verdict;
  tlp_class_e          upd_cls;
  logic [9:0]          upd_len;
  logic                upd_strobe;

  dll_rx_framer u_framer (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .s_word_i     (s_word_i),
    .s_valid_i    (s_valid_i),
    .s_ready_o    (s_ready_o),
    .rx_word_o    (rx_word),
    .rx_valid_o   (rx_valid),
    .rx_take_i    (rx_take),
    .lcrc_word_o  (lcrc_word),
    .lcrc_valid_o (lcrc_valid)
  );

  lcrc32_calc u_lcrc (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .word_i  (rx_word.data),
    .take_i  (rx_take),
    .clear_i (crc_clear),
    .crc_o   (crc)
  );

  tlp_rx_checker u_checker (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .link_active_i   (link_active_i),
    .rx_word_i       (rx_word),
    .rx_valid_i      (rx_valid),
    .rx_take_o       (rx_take),
    .fifo_space_i    (fifo_space),
    .lcrc_word_i     (lcrc_word),
    .lcrc_valid_i    (lcrc_valid),
    .crc_i           (crc),
    .crc_clear_o     (crc_clear),
    .verdict_o       (verdict),
    .cls_o           (upd_cls),
    .length_dw_o     (upd_len),
    .update_o        (upd_strobe),
    .fc_start_o      (fc_start_o),
    .fc_start_ack_i  (fc_start_ack_i),
    .rx_seq_o        (rx_seq_o),
    .tlp_nullified_o (tlp_nullified_o)
  );

  fc_credit_counter #(
    .MAX_PAYLOAD_DW (MAX_PAYLOAD_DW)
  ) u_credits (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cls_i       (upd_cls),
    .length_dw_i (upd_len),
    .update_i    (upd_strobe),
    .credits_o   (credits_o)
  );

  tlp_frame_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .wr_word_i (rx_word),
    .wr_take_i (rx_take),
    .space_o   (fifo_space),
    .verdict_i (verdict),
    .m_word_o  (m_word_o),
    .m_valid_o (m_valid_o),
    .m_ready_i (m_ready_i)
  );

endmodule

`default_nettype wire

// ==== rtl/fc_credit_counter.sv ====
// ************************************************************
// consumed credits for posted and non-posted TLPs
// length 0 counts as one data credit; counters wrap
// ************************************************************
`timescale 1ns/1ps
`default_nettype none

module fc_credit_counter
  import dll_rx_pkg::*;
#(
  parameter int MAX_PAYLOAD_DW = 64
) (
  input  logic           clk_i,
  input  logic           rst_i,
  input  tlp_class_e     cls_i,
  input  logic [9:0]     length_dw_i,
  input  logic           update_i,
  output credit_counts_t credits_o
);

  localparam logic [CRED_DATA_WIDTH-1:0] DATA_MIN_CREDITS =
    CRED_DATA_WIDTH'(MAX_PAYLOAD_DW / 4);

  logic [CRED_DATA_WIDTH-1:0] data_inc;

  // one data credit per 4 dwords, at least one
  assign data_inc = (length_dw_i[9:2] == '0) ?
                    CRED_DATA_WIDTH'(1) : CRED_DATA_WIDTH'(length_dw_i[9:2]);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      credits_o.ph  <= HDR_MIN_CREDITS;
      credits_o.pd  <= DATA_MIN_CREDITS;
      credits_o.nph <= HDR_MIN_CREDITS;
      credits_o.npd <= DATA_MIN_CREDITS;
    end else if (update_i) begin
      case (cls_i)
        CLS_PH: credits_o.ph <= credits_o.ph + 1'b1;
        CLS_PD: begin
          credits_o.ph <= credits_o.ph + 1'b1;
          credits_o.pd <= credits_o.pd + data_inc;
        end
        CLS_NPH: credits_o.nph <= credits_o.nph + 1'b1;
        CLS_NPD: begin
          credits_o.nph <= credits_o.nph + 1'b1;
          credits_o.npd <= credits_o.npd + data_inc;
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/lcrc32_calc.sv ====
// ************************************************************
// reflected CRC-32 over whole dwords, byte 0 first
// crc_o is already inverted for direct LCRC compare
// ************************************************************
`timescale 1ns/1ps
`default_nettype none

module lcrc32_calc
  import dll_rx_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic [DW_WIDTH-1:0] word_i,
  input  logic                take_i,
  input  logic                clear_i,
  output logic [DW_WIDTH-1:0] crc_o
);

  logic [DW_WIDTH-1:0] crc_q;
  logic [DW_WIDTH-1:0] crc_next;
  logic [DW_WIDTH-1:0] poly_refl;

  always_comb begin
    for (int i = 0; i < DW_WIDTH; i++) begin
      poly_refl[i] = LCRC_POLY[DW_WIDTH-1-i];
    end
    crc_next = crc_q;
    // bit order of the word is already lsb first per byte
    for (int i = 0; i < DW_WIDTH; i++) begin
      if (crc_next[0] ^ word_i[i]) begin
        crc_next = (crc_next >> 1) ^ poly_refl;
      end else begin
        crc_next = crc_next >> 1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || clear_i) begin
      crc_q <= LCRC_INIT;
    end else if (take_i) begin
      crc_q <= crc_next;
    end
  end

  assign crc_o = ~crc_q;

endmodule

`default_nettype wire

// ==== rtl/tlp_frame_fifo.sv ====
// ************************************************************
// frame FIFO towards the transaction layer
// words are written at a tentative pointer; a good verdict
// commits them, a bad one rewinds. FIFO_DEPTH power of two
// ************************************************************
`timescale 1ns/1ps
`default_nettype none

module tlp_frame_fifo
  import dll_rx_pkg::*;
#(
  parameter int FIFO_DEPTH = 256
) (
  input  logic           clk_i,
  input  logic           rst_i,
  input  rx_word_t       wr_word_i,
  input  logic           wr_take_i,
  output logic           space_o,
  input  frame_verdict_t verdict_i,
  output axis_word_t     m_word_o,
  output logic           m_valid_o,
  input  logic           m_ready_i
);

  localparam int AW = $clog2(FIFO_DEPTH);

  axis_word_t  mem [FIFO_DEPTH];
  logic [AW:0] tent_q;
  logic [AW:0] commit_q;
  logic [AW:0] rd_q;
  logic [AW:0] tent_next;
  logic [AW:0] rd_next;
  logic        wr_en;
  logic        rd_en;
  logic        space_q;

  // sequence word is not part of the TLP
  assign wr_en     = wr_take_i && !wr_word_i.first;
  assign m_valid_o = (rd_q != commit_q);
  assign rd_en     = m_valid_o && m_ready_i;
  assign m_word_o  = mem[rd_q[AW-1:0]];
  assign space_o   = space_q;

  always_comb begin
    tent_next = tent_q;
    if (verdict_i.valid && !verdict_i.good) begin
      tent_next = commit_q;
    end else if (wr_en) begin
      tent_next = tent_q + 1'b1;
    end
    rd_next = rd_en ? rd_q + 1'b1 : rd_q;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      tent_q   <= '0;
      commit_q <= '0;
      rd_q     <= '0;
      space_q  <= 1'b0;
    end else begin
      tent_q  <= tent_next;
      rd_q    <= rd_next;
      space_q <= (tent_next - rd_next) != (AW + 1)'(FIFO_DEPTH);
      if (verdict_i.valid && verdict_i.good) begin
        commit_q <= tent_q;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem[tent_q[AW-1:0]] <= '{data: wr_word_i.data, last: wr_word_i.last};
    end
  end

endmodule

`default_nettype wire

// ==== rtl/tlp_rx_checker.sv ====
// ************************************************************
// per-frame control of the receive path
// verdict, credit update and fc start come one cycle after
// the LCRC word; no new frame until fc_start_ack_i
// ************************************************************
`timescale 1ns/1ps
`default_nettype none

module tlp_rx_checker
  import dll_rx_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 link_active_i,
  input  rx_word_t             rx_word_i,
  input  logic                 rx_valid_i,
  output logic                 rx_take_o,
  input  logic                 fifo_space_i,
  input  logic [DW_WIDTH-1:0]  lcrc_word_i,
  input  logic                 lcrc_valid_i,
  input  logic [DW_WIDTH-1:0]  crc_i,
  output logic                 crc_clear_o,
  output frame_verdict_t       verdict_o,
  output tlp_class_e           cls_o,
  output logic [9:0]           length_dw_o,
  output logic                 update_o,
  output logic                 fc_start_o,
  input  logic                 fc_start_ack_i,
  output logic [SEQ_WIDTH-1:0] rx_seq_o,
  output logic                 tlp_nullified_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_HEADER,
    ST_BODY,
    ST_CHECK,
    ST_WAIT_ACK
  } chk_state_e;

  chk_state_e           state_q;
  logic [SEQ_WIDTH-1:0] seq_q;
  logic [SEQ_WIDTH-1:0] exp_seq_q;
  logic [DW_WIDTH-1:0]  lcrc_q;
  tlp_class_e           cls_q;
  logic [9:0]           len_q;
  logic                 null_q;
  tlp_dw0_t             dw0;
  tlp_class_e           cls_dec;
  logic                 receiving;
  logic                 good;

  assign dw0 = rx_word_i.data;

  always_comb begin
    case (dw0.fmt_type)
      MRd32, MRd64, MRdLk, IORd, CfgRd0, CfgRd1:       cls_dec = CLS_NPH;
      IOWr, CfgWr0, CfgWr1, FetchAdd, Swap, CAS:        cls_dec = CLS_NPD;
      Msg:                                              cls_dec = CLS_PH;
      MWr32, MWr64, MsgD:                               cls_dec = CLS_PD;
      // completions and unknown codes
      default:                                          cls_dec = CLS_NONE;
    endcase
  end

  assign receiving = link_active_i &&
                     (state_q == ST_IDLE || state_q == ST_HEADER || state_q == ST_BODY);
  assign rx_take_o = rx_valid_i && receiving && fifo_space_i;
  assign good      = (crc_i == lcrc_q) && (seq_q == exp_seq_q);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= ST_IDLE;
      seq_q     <= '0;
      exp_seq_q <= '0;
      null_q    <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (rx_take_o) begin
            seq_q   <= rx_word_i.data[SEQ_WIDTH-1:0];
            state_q <= ST_HEADER;
          end
        end
        ST_HEADER: begin
          if (rx_take_o) begin
            state_q <= rx_word_i.last ? ST_CHECK : ST_BODY;
          end
        end
        ST_BODY: begin
          if (rx_take_o && rx_word_i.last) begin
            state_q <= ST_CHECK;
          end
        end
        ST_CHECK: begin
          null_q  <= !good;
          state_q <= ST_WAIT_ACK;
        end
        ST_WAIT_ACK: begin
          if (fc_start_ack_i) begin
            // 12-bit counter wraps at 4096
            if (!null_q) begin
              exp_seq_q <= exp_seq_q + 1'b1;
            end
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ST_HEADER && rx_take_o) begin
      cls_q <= cls_dec;
      len_q <= {dw0.length_hi, dw0.length_lo};
    end
    if (rx_take_o && lcrc_valid_i) begin
      lcrc_q <= lcrc_word_i;
    end
  end

  always_comb begin
    verdict_o.valid = (state_q == ST_CHECK);
    verdict_o.good  = good;
    update_o        = (state_q == ST_CHECK) && good;
    crc_clear_o     = (state_q == ST_CHECK);
    fc_start_o      = (state_q == ST_CHECK) || (state_q == ST_WAIT_ACK);
    tlp_nullified_o = (state_q == ST_CHECK) ? !good : null_q;
  end

  assign cls_o       = cls_q;
  assign length_dw_o = len_q;
  assign rx_seq_o    = seq_q;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the DLL receive testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_dll_rx -f verilog.f -o sim_tb_dll_rx
./obj_dir/sim_tb_dll_rx > sim.log 2>&1
cat sim.log

if grep -qx '>>> PASS' sim.log; then
  exit 0
fi
exit 1

// ==== sim/tb_dll_rx.sv ====
// ************************************************************
// directed testbench for dll_rx_top
// LCRC comes from a byte-wise reference CRC-32 model
// fc_start_o is acknowledged by a background process
// ************************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_dll_rx
  import dll_rx_pkg::*;
();

  localparam int CLK_PERIOD     = 40;
  localparam int MAX_PAYLOAD_DW = 64;
  // sum of all frame lengths in words, sequence and LCRC included
  localparam int FRAME_WORDS    = 83;
  localparam int WATCHDOG_NS    = (FRAME_WORDS * 40 + 200) * CLK_PERIOD;

  logic                 clk_i;
  logic                 rst_i;
  logic                 link_active_i;
  axis_word_t           s_word_i;
  logic                 s_valid_i;
  logic                 s_ready_o;
  axis_word_t           m_word_o;
  logic                 m_valid_o;
  logic                 m_ready_i;
  logic                 fc_start_o;
  logic                 fc_start_ack_i;
  logic [SEQ_WIDTH-1:0] rx_seq_o;
  logic                 tlp_nullified_o;
  credit_counts_t       credits_o;

  logic [31:0]          lcg_state;
  logic [SEQ_WIDTH-1:0] exp_seq;
  credit_counts_t       exp_cred;
  axis_word_t           exp_q [$];
  axis_word_t           got_q [$];
  int                   errors;
  int                   tests_run;
  int                   tests_failed;
  int                   test_err_start;

  dll_rx_top #(
    .MAX_PAYLOAD_DW (MAX_PAYLOAD_DW),
    .RX_FIFO_FRAMES (2)
  ) u_dut (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .link_active_i   (link_active_i),
    .s_word_i        (s_word_i),
    .s_valid_i       (s_valid_i),
    .s_ready_o       (s_ready_o),
    .m_word_o        (m_word_o),
    .m_valid_o       (m_valid_o),
    .m_ready_i       (m_ready_i),
    .fc_start_o      (fc_start_o),
    .fc_start_ack_i  (fc_start_ack_i),
    .rx_seq_o        (rx_seq_o),
    .tlp_nullified_o (tlp_nullified_o),
    .credits_o       (credits_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // every transfer towards the transaction layer
  always @(posedge clk_i) begin
    if (!rst_i && m_valid_o && m_ready_i) begin
      got_q.push_back(m_word_o);
    end
  end

  // ack each fc start two cycles after it is seen
  initial begin
    fc_start_ack_i = 1'b0;
    forever begin
      @(negedge clk_i);
      if (fc_start_o === 1'b1) begin
        repeat (2) @(negedge clk_i);
        fc_start_ack_i = 1'b1;
        while (fc_start_o) @(negedge clk_i);
        fc_start_ack_i = 1'b0;
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
    $display(">>> FAIL");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // standard reflected CRC-32, byte 0 of each dword first
  function automatic logic [31:0] ref_lcrc(input logic [31:0] words [$]);
    logic [31:0] c;
    c = 32'hFFFF_FFFF;
    foreach (words[i]) begin
      for (int b = 0; b < 4; b++) begin
        c = c ^ {24'h0, words[i][8*b +: 8]};
        for (int k = 0; k < 8; k++) begin
          c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
        end
      end
    end
    return ~c;
  endfunction

  function automatic credit_counts_t add_credits(input credit_counts_t c,
                                                 input tlp_fmt_type_e fmt, input int len);
    logic [11:0] d;
    d = (len / 4 == 0) ? 12'd1 : 12'(len / 4);
    case (fmt)
      MWr32, MWr64, MsgD: begin
        c.ph = c.ph + 8'd1;
        c.pd = c.pd + d;
      end
      Msg: c.ph = c.ph + 8'd1;
      IOWr, CfgWr0, CfgWr1, FetchAdd, Swap, CAS: begin
        c.nph = c.nph + 8'd1;
        c.npd = c.npd + d;
      end
      MRd32, MRd64, MRdLk, IORd, CfgRd0, CfgRd1: c.nph = c.nph + 8'd1;
      default: ;
    endcase
    return c;
  endfunction

  task automatic check_word(input axis_word_t got, input axis_word_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s got %h last %b, expected %h last %b",
               $time, what, got.data, got.last, exp.data, exp.last);
    end
  endtask

  task automatic check_credits(input credit_counts_t got, input credit_counts_t exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: credits %0d %0d %0d %0d, expected %0d %0d %0d %0d",
               $time, got.ph, got.pd, got.nph, got.npd, exp.ph, exp.pd, exp.nph, exp.npd);
    end
  endtask

  task automatic check_seq(input logic [SEQ_WIDTH-1:0] got, input logic [SEQ_WIDTH-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: rx_seq_o %0d, expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic send_word(input logic [31:0] data, input logic last);
    @(negedge clk_i);
    s_word_i  = '{data: data, last: last};
    s_valid_i = 1'b1;
    do begin
      @(posedge clk_i);
      // no word enters while a finished frame awaits its acknowledge
      if (fc_start_o) begin
        check_flag(s_ready_o, 1'b0, "s_ready_o before fc acknowledge");
      end
    end while (!s_ready_o);
  endtask

  // 3 header dwords plus payload; model is updated for good frames only
  task automatic send_frame(input logic [SEQ_WIDTH-1:0] seq, input tlp_fmt_type_e fmt,
                            input int len, input int payload_dw, input bit bad_crc);
    logic [31:0] tlp [$];
    logic [31:0] crc_words [$];
    logic [31:0] lcrc;
    logic [9:0]  len10;
    tlp_dw0_t    dw0;
    bit          good;
    len10         = 10'(len);
    dw0           = '0;
    dw0.fmt_type  = fmt;
    dw0.length_hi = len10[9:8];
    dw0.length_lo = len10[7:0];
    tlp.push_back(dw0);
    for (int i = 0; i < 2 + payload_dw; i++) begin
      tlp.push_back(next_rand());
    end
    crc_words = tlp;
    crc_words.push_front({20'h0, seq});
    lcrc = ref_lcrc(crc_words);
    if (bad_crc) begin
      lcrc = lcrc ^ 32'h0000_0001;
    end
    good = !bad_crc && (seq == exp_seq);
    send_word({20'h0, seq}, 1'b0);
    foreach (tlp[i]) begin
      send_word(tlp[i], 1'b0);
    end
    send_word(lcrc, 1'b1);
    @(negedge clk_i);
    s_valid_i = 1'b0;
    if (good) begin
      exp_seq  = exp_seq + 1'b1;
      exp_cred = add_credits(exp_cred, fmt, len);
      foreach (tlp[i]) begin
        exp_q.push_back('{data: tlp[i], last: (i == tlp.size() - 1)});
      end
    end
  endtask

  task automatic wait_frame_done();
    while (!fc_start_o) @(negedge clk_i);
    while (fc_start_o) @(negedge clk_i);
  endtask

  task automatic check_output();
    axis_word_t got;
    axis_word_t exp;
    while (got_q.size() < exp_q.size()) @(negedge clk_i);
    while (exp_q.size() > 0) begin
      got = got_q.pop_front();
      exp = exp_q.pop_front();
      check_word(got, exp, "output word");
    end
    if (got_q.size() != 0) begin
      errors++;
      $display("unexpected output: %0d words more than expected", got_q.size());
      got_q.delete();
    end
    check_flag(m_valid_o, 1'b0, "m_valid_o after frame");
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == test_err_start) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - test_err_start);
    end
    test_err_start = errors;
  endtask

  task automatic test_reset();
    check_flag(m_valid_o, 1'b0, "m_valid_o");
    check_flag(fc_start_o, 1'b0, "fc_start_o");
    check_flag(tlp_nullified_o, 1'b0, "tlp_nullified_o");
    check_seq(rx_seq_o, 12'd0);
    check_credits(credits_o, exp_cred);
    finish_test("reset");
  endtask

  task automatic test_good_write();
    send_frame(12'd0, MWr32, 8, 8, 1'b0);
    wait_frame_done();
    check_output();
    check_credits(credits_o, exp_cred);
    check_seq(rx_seq_o, 12'd0);
    check_flag(tlp_nullified_o, 1'b0, "tlp_nullified_o");
    finish_test("good_write");
  endtask

  task automatic test_bad_lcrc();
    logic [SEQ_WIDTH-1:0] seq;
    seq = exp_seq;
    send_frame(seq, MWr32, 4, 4, 1'b1);
    wait_frame_done();
    check_output();
    check_credits(credits_o, exp_cred);
    check_flag(tlp_nullified_o, 1'b1, "tlp_nullified_o on bad LCRC");
    // retry with the same sequence
    send_frame(seq, MWr32, 4, 4, 1'b0);
    wait_frame_done();
    check_output();
    check_credits(credits_o, exp_cred);
    check_seq(rx_seq_o, seq);
    check_flag(tlp_nullified_o, 1'b0, "tlp_nullified_o on retry");
    finish_test("bad_lcrc");
  endtask

  task automatic test_bad_seq();
    logic [SEQ_WIDTH-1:0] seq;
    seq = exp_seq + 12'd5;
    send_frame(seq, MWr32, 4, 4, 1'b0);
    wait_frame_done();
    check_output();
    check_credits(credits_o, exp_cred);
    check_seq(rx_seq_o, seq);
    check_flag(tlp_nullified_o, 1'b1, "tlp_nullified_o on bad sequence");
    finish_test("bad_seq");
  endtask

  task automatic test_non_posted();
    send_frame(exp_seq, MRd32, 1, 0, 1'b0);
    wait_frame_done();
    check_output();
    check_credits(credits_o, exp_cred);
    check_flag(tlp_nullified_o, 1'b0, "tlp_nullified_o after MRd32");
    send_frame(exp_seq, CfgWr0, 1, 1, 1'b0);
    wait_frame_done();
    check_output();
    check_credits(credits_o, exp_cred);
    check_flag(tlp_nullified_o, 1'b0, "tlp_nullified_o after CfgWr0");
    finish_test("non_posted");
  endtask

  task automatic test_backpressure();
    logic [SEQ_WIDTH-1:0] seq0;
    seq0 = exp_seq;
    @(negedge clk_i);
    m_ready_i = 1'b0;
    for (int i = 0; i < 3; i++) begin
      send_frame(seq0 + 12'(i), MWr32, 4, 4, 1'b0);
    end
    wait_frame_done();
    check_flag(m_valid_o, 1'b1, "m_valid_o while held");
    m_ready_i = 1'b1;
    check_output();
    check_seq(rx_seq_o, seq0 + 12'd2);
    check_flag(tlp_nullified_o, 1'b0, "tlp_nullified_o after held frames");
    // accepted only if the expected sequence moved by three
    send_frame(seq0 + 12'd3, MRd32, 1, 0, 1'b0);
    wait_frame_done();
    check_output();
    check_credits(credits_o, exp_cred);
    check_flag(tlp_nullified_o, 1'b0, "tlp_nullified_o after sequence check");
    finish_test("backpressure");
  endtask

  initial begin
    clk_i          = 1'b0;
    rst_i          = 1'b1;
    link_active_i  = 1'b1;
    s_word_i       = '0;
    s_valid_i      = 1'b0;
    m_ready_i      = 1'b1;
    lcg_state      = 32'h377c_b9da;
    exp_seq        = '0;
    exp_cred       = '{ph: 8'd1, pd: 12'(MAX_PAYLOAD_DW / 4),
                       nph: 8'd1, npd: 12'(MAX_PAYLOAD_DW / 4)};
    errors         = 0;
    tests_run      = 0;
    tests_failed   = 0;
    test_err_start = 0;
    repeat (16) @(negedge clk_i);
    rst_i = 1'b0;
    @(negedge clk_i);
    test_reset();
    test_good_write();
    test_bad_lcrc();
    test_bad_seq();
    test_non_posted();
    test_backpressure();
    $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/dll_rx_pkg.sv
rtl/lcrc32_calc.sv
rtl/dll_rx_framer.sv
rtl/tlp_rx_checker.sv
rtl/fc_credit_counter.sv
rtl/tlp_frame_fifo.sv
rtl/dll_rx_top.sv
sim/tb_dll_rx.sv
